/* sine_synth_pkg.sv */
/* common definitions for the stereo I2S test-signal generator
   widths, CORDIC constants, LFSR constants and the angle word
   every block refers to these by scoped name */
package sine_synth_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int sample_w = 16;       // DAC word, one channel
	localparam int phase_w  = 32;       // full turn = 2^32

	typedef logic signed [sample_w-1:0] sample_t;   // two's complement audio word

	// the angle word is read two ways by the CORDIC front end
	typedef union packed {
		logic signed [phase_w-1:0] signed_angle;    // -pi .. +pi
		struct packed {
			logic [1:0]         quadrant;           // which quarter turn
			logic [phase_w-3:0] residual;           // position inside it
		} fold;
	} angle_t;

	// --------------------
	// CORDIC
	// --------------------
	localparam int cordic_iters = 11;   // enough for 12 bit output

	// atan(2^-i) scaled so that 2^32 is a full turn
	localparam logic signed [phase_w-1:0] atan_table [cordic_iters] = '{
		32'h2000_0000,  // 45 deg
		32'h12E4_051D,  // 26.565 deg
		32'h09FB_385B,  // 14.036 deg
		32'h0511_11D4,
		32'h028B_0D43,
		32'h0145_D7E1,
		32'h00A2_F61E,
		32'h0051_7C55,
		32'h0028_BE53,
		32'h0014_5F2E,
		32'h000A_2F98   // last one used at 12 bit
	};

	// 1000 / 1.647, gain compensated start so the peak lands near 1000
	localparam logic signed [11:0] cordic_x_start = 12'sd607;

	// --------------------
	// noise source
	// --------------------
	localparam logic [31:0] lfsr_seed = 32'hABAB_ABAB;     // start state
	localparam logic [30:0] lfsr_taps = 31'h0000_0062;     // feedback taps

	// --------------------
	// I2S framing
	// --------------------
	localparam int bits_per_frame = 32;     // 16 left + 16 right

endpackage

/* i2s_timing.sv */
`timescale 1ns/100ps
/* bit clock and word clock generator for the I2S DAC
   also flags each falling bck edge and the frame wrap for the data path */
module i2s_timing #(
	parameter int bck_half_cycles = 4   // clk cycles per bck half period
) (
	input  logic clk,
	input  logic arst_n,
	output logic bck,
	output logic lrck,
	output logic shift_en,              // one cycle, with each bck fall
	output logic frame_start            // one cycle, with the frame wrap
);

	localparam int div_w  = (bck_half_cycles > 1) ? $clog2(bck_half_cycles) : 1;
	localparam int half_w = $clog2(2 * sine_synth_pkg::bits_per_frame);    // 6 bits
	localparam logic [div_w-1:0]  div_last  = div_w'(bck_half_cycles - 1);
	localparam logic [half_w-1:0] half_last = half_w'(2 * sine_synth_pkg::bits_per_frame - 1);

	logic [div_w-1:0]  div_cnt;         // clk divider
	logic [half_w-1:0] half_cnt;        // bck half periods within the frame
	logic              tick;            // end of a bck half period

	assign tick = (div_cnt == div_last);

	// --------------------
	// counters
	// --------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt  <= '0;
			half_cnt <= '0;
		end else if (tick) begin
			div_cnt  <= '0;
			half_cnt <= half_cnt + 1'b1;    // wraps at end of frame
		end else begin
			div_cnt  <= div_cnt + 1'b1;
		end
	end

	// bit 0 is the bit clock itself
	assign bck  = half_cnt[0];
	// msb flips only when bit 0 falls, so lrck moves on a falling bck edge
	assign lrck = half_cnt[half_w-1];

	// bck high at a tick means it goes low on this edge
	assign shift_en    = tick & bck;
	assign frame_start = tick & (half_cnt == half_last);   // 63 -> 0

endmodule

/* sample_sequencer.sv */
`timescale 1ns/100ps
/* per-frame control for the sample path
   advances the phase, starts one CORDIC item and one noise step per frame,
   and holds the scaled sine for the serializer */
module sample_sequencer #(
	parameter int cordic_width = 12
) (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                frame_start,
	input  logic [sine_synth_pkg::phase_w-1:0]  phase_step,     // added once per frame
	input  logic signed [cordic_width-1:0]      sine,
	input  logic                                out_valid,
	output sine_synth_pkg::angle_t              angle,
	output logic                                in_valid,
	output logic                                step,
	output sine_synth_pkg::sample_t             right_sample
);

	// FSM encoding
	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_issue = 2'd1;
	localparam logic [1:0] st_wait  = 2'd2;

	localparam int scale_sh = sine_synth_pkg::sample_w - cordic_width;   // 12 -> 16 bit

	logic [1:0]                       state;
	logic [sine_synth_pkg::phase_w-1:0] phase_acc;

	// --------------------
	// FSM and phase
	// --------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= st_idle;
			phase_acc    <= '0;
			right_sample <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (frame_start)
						state <= st_issue;
				end
				st_issue: begin
					// cordic takes the old phase on this edge
					phase_acc <= phase_acc + phase_step;
					state     <= st_wait;
				end
				st_wait: begin
					if (out_valid) begin
						right_sample <= sine_synth_pkg::sample_t'(sine) <<< scale_sh;
						state        <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign angle.signed_angle = phase_acc;

	// both pulses last exactly the one issue cycle
	assign in_valid = (state == st_issue);
	assign step     = (state == st_issue);  // noise advances next cycle

endmodule

/* cordic_sine.sv */
`timescale 1ns/100ps
/* pipelined rotation-mode CORDIC giving the sine of a 32 bit phase
   one fold stage plus cordic_iters shift-add stages, fully pipelined
   so a new angle may enter every cycle; a valid bit runs alongside */
module cordic_sine #(
	parameter int cordic_width = 12
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  sine_synth_pkg::angle_t          angle,
	input  logic                            in_valid,
	output logic signed [cordic_width-1:0]  sine,
	output logic                            out_valid
);

	localparam int n     = sine_synth_pkg::cordic_iters;
	localparam int z_msb = sine_synth_pkg::phase_w - 1;

	// one guard bit above the output width
	localparam logic signed [cordic_width:0] x_init =
		(cordic_width + 1)'(sine_synth_pkg::cordic_x_start);
	localparam logic signed [cordic_width:0] y_init = 1;

	logic signed [cordic_width:0] x [0:n-1];   // cosine path, last stage not needed
	logic signed [cordic_width:0] y [0:n];     // sine path
	logic signed [z_msb:0]        z [0:n-1];   // remaining angle
	logic [n:0]                   vld;         // valid per stage

	// --------------------
	// fold and rotate
	// --------------------
	always_ff @(posedge clk) begin
		// bring the angle into -90 .. +90 deg
		case (angle.fold.quadrant)
			2'b01: begin
				x[0] <= -y_init;
				y[0] <= x_init;
				z[0] <= {2'b00, angle.fold.residual};  // minus 90 deg
			end
			2'b10: begin
				x[0] <= y_init;
				y[0] <= -x_init;
				z[0] <= {2'b11, angle.fold.residual};  // plus 90 deg
			end
			default: begin
				x[0] <= x_init;                         // already in range
				y[0] <= y_init;
				z[0] <= angle.signed_angle;
			end
		endcase

		// stage i rotates by atan(2^-i), direction from sign of z
		for (int i = 0; i < n - 1; i++) begin
			if (z[i][z_msb]) begin
				x[i+1] <= x[i] + (y[i] >>> i);
				y[i+1] <= y[i] - (x[i] >>> i);
				z[i+1] <= z[i] + sine_synth_pkg::atan_table[i];
			end else begin
				x[i+1] <= x[i] - (y[i] >>> i);
				y[i+1] <= y[i] + (x[i] >>> i);
				z[i+1] <= z[i] - sine_synth_pkg::atan_table[i];
			end
		end

		// last stage only needs y
		if (z[n-1][z_msb])
			y[n] <= y[n-1] - (x[n-1] >>> (n - 1));
		else
			y[n] <= y[n-1] + (x[n-1] >>> (n - 1));
	end

	// --------------------
	// valid pipe
	// --------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			vld <= '0;
		else
			vld <= {vld[n-1:0], in_valid};  // n+1 stages deep
	end

	assign out_valid = vld[n];
	assign sine      = y[n][cordic_width-1:0];   // peak about 1000, guard bit dropped

endmodule

/* lfsr_noise.sv */
`timescale 1ns/100ps
/* white noise source for the left channel
   32 bit Galois LFSR, advanced once per step pulse, upper half is the sample */
module lfsr_noise (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    step,           // one cycle per frame
	output sine_synth_pkg::sample_t left_sample
);

	logic [31:0] lfsr;

	// --------------------
	// shift register
	// --------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= sine_synth_pkg::lfsr_seed;
		end else if (step) begin
			// msb rotates into bit 0, taps flip when it was set
			lfsr <= {lfsr[30:0] ^ (lfsr[31] ? sine_synth_pkg::lfsr_taps : 31'd0),
				lfsr[31]};
		end
	end

	assign left_sample = sine_synth_pkg::sample_t'(lfsr[31:16]);   // top 16 bits

endmodule

/* i2s_serializer.sv */
`timescale 1ns/100ps
/* frame shift register for the DAC data line
   loads left above right at the frame wrap, then one bit out per bck fall,
   msb of left first, so din changes together with bck going low */
module i2s_serializer (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    shift_en,
	input  logic                    frame_start,
	input  sine_synth_pkg::sample_t left_sample,
	input  sine_synth_pkg::sample_t right_sample,
	output logic                    din
);

	localparam int frame_w = 2 * sine_synth_pkg::sample_w;     // 32

	logic [frame_w-1:0] frame_sr;       // left in the upper half

	// --------------------
	// load / shift
	// --------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_sr <= '0;             // keeps din low until the first frame
		end else if (frame_start) begin
			// frame_start comes with a shift_en, load wins
			frame_sr <= {left_sample, right_sample};
		end else if (shift_en) begin
			frame_sr <= {frame_sr[frame_w-2:0], 1'b0};
		end
	end

	// msb is on the line straight after the load edge
	assign din = frame_sr[frame_w-1];

endmodule

/* sine_synth_top.sv */
`timescale 1ns/100ps
/* stereo test-signal generator for a PCM5102 style I2S DAC
   left = LFSR noise, right = CORDIC sine stepped by phase_step each frame */
module sine_synth_top #(
	parameter int bck_half_cycles = 4,  // bck = clk / (2 * this)
	parameter int cordic_width    = 12
) (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic [sine_synth_pkg::phase_w-1:0] phase_step,   // tone frequency
	output logic                               din,
	output logic                               bck,
	output logic                               lrck
);

	// timing strobes
	logic shift_en;
	logic frame_start;

	// sequencer <-> cordic
	sine_synth_pkg::angle_t          angle;
	logic                            in_valid;
	logic signed [cordic_width-1:0]  sine;
	logic                            out_valid;

	// samples and noise step
	logic                            step;
	sine_synth_pkg::sample_t         left_sample;
	sine_synth_pkg::sample_t         right_sample;

	// --------------------
	// instances
	// --------------------
	i2s_timing #(
		.bck_half_cycles(bck_half_cycles)
	) u_timing (
		.clk         (clk),
		.arst_n      (arst_n),
		.bck         (bck),
		.lrck        (lrck),
		.shift_en    (shift_en),
		.frame_start (frame_start)
	);

	sample_sequencer #(
		.cordic_width(cordic_width)
	) u_seq (
		.clk          (clk),
		.arst_n       (arst_n),
		.frame_start  (frame_start),
		.phase_step   (phase_step),
		.sine         (sine),
		.out_valid    (out_valid),
		.angle        (angle),
		.in_valid     (in_valid),
		.step         (step),
		.right_sample (right_sample)
	);

	cordic_sine #(
		.cordic_width(cordic_width)
	) u_cordic (
		.clk       (clk),
		.arst_n    (arst_n),
		.angle     (angle),
		.in_valid  (in_valid),
		.sine      (sine),
		.out_valid (out_valid)
	);

	lfsr_noise u_noise (
		.clk         (clk),
		.arst_n      (arst_n),
		.step        (step),
		.left_sample (left_sample)
	);

	// words latched this frame go out during the next one
	i2s_serializer u_ser (
		.clk          (clk),
		.arst_n       (arst_n),
		.shift_en     (shift_en),
		.frame_start  (frame_start),
		.left_sample  (left_sample),
		.right_sample (right_sample),
		.din          (din)
	);

endmodule

/* sine_synth_assert.sv */
`timescale 1ns/100ps
/* port timing checks for the I2S generator, bound into the top level
   covers the reset state, the bck period and the lrck / din edge rules */
module sine_synth_assert #(
	parameter int bck_half_cycles = 4
) (
	input logic clk,
	input logic arst_n,
	input logic bck,
	input logic lrck,
	input logic din
);

	logic       bck_q;          // last sampled levels
	logic       lrck_q;
	logic       bck_armed;      // first bck edge seen
	logic       lrck_armed;     // first lrck edge seen
	logic [7:0] run;            // clk samples at the current bck level
	logic [4:0] falls;          // bck falls inside the current lrck level
	int         fails = 0;      // failed assertion count

	// --------------------
	// helper state
	// --------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bck_q      <= 1'b0;
			lrck_q     <= 1'b0;
			bck_armed  <= 1'b0;
			lrck_armed <= 1'b0;
			run        <= 8'd0;
			falls      <= 5'd0;
		end else begin
			bck_q  <= bck;
			lrck_q <= lrck;
			if (bck != bck_q) begin
				run       <= 8'd1;
				bck_armed <= 1'b1;
			end else begin
				run <= run + 8'd1;
			end
			if (lrck != lrck_q) begin
				falls      <= 5'd0;     // new level starts
				lrck_armed <= 1'b1;
			end else if (bck_q && !bck) begin
				falls <= falls + 5'd1;
			end
		end
	end

	// all outputs quiet in reset and until bck first moves
	reset_quiet: assert property (@(posedge clk) !arst_n |-> (!bck && !lrck && !din))
		else begin
			$error("outputs not low during reset");
			fails++;
		end
	start_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		!bck_armed |-> (!lrck && !din))
		else begin
			$error("lrck or din moved before the first bck edge");
			fails++;
		end

	// each bck level lasts bck_half_cycles clk cycles
	bck_period: assert property (@(posedge clk) disable iff (!arst_n)
		(bck_armed && bck != bck_q) |-> (run == 8'(bck_half_cycles)))
		else begin
			$error("bck half period wrong");
			fails++;
		end

	// lrck and din only move when bck falls
	lrck_edge: assert property (@(posedge clk) disable iff (!arst_n)
		(lrck != lrck_q) |-> (bck_q && !bck))
		else begin
			$error("lrck changed away from a falling bck edge");
			fails++;
		end
	din_edge: assert property (@(posedge clk) disable iff (!arst_n)
		($changed(din)) |-> (bck_q && !bck))
		else begin
			$error("din changed away from a falling bck edge");
			fails++;
		end

	// 16 bck periods per channel, the last fall is the lrck edge itself
	lrck_length: assert property (@(posedge clk) disable iff (!arst_n)
		(lrck_armed && lrck != lrck_q) |-> (falls == 5'd15))
		else begin
			$error("lrck level not 16 bck periods long");
			fails++;
		end

endmodule

bind sine_synth_top sine_synth_assert #(
	.bck_half_cycles(bck_half_cycles)
) u_assert (
	.clk    (clk),
	.arst_n (arst_n),
	.bck    (bck),
	.lrck   (lrck),
	.din    (din)
);

/* tb_sine_synth.sv */
`timescale 1ns/100ps
/* testbench for the I2S test-signal generator
   captures din per frame, checks noise against a model and the sine values */
module tb_sine_synth;

	localparam int wait_limit = 200;        // clk cycles per single wait

	logic        clk;
	logic        arst_n;
	logic [31:0] phase_step;
	logic        din;
	logic        bck;
	logic        lrck;

	logic               bck_prev;
	logic               lrck_prev;
	logic [31:0]        noise_model;        // reference LFSR state
	logic signed [15:0] right_w;            // right word of last frame
	int                 seed;
	int                 errs_noise;
	int                 errs_const;
	int                 errs_quarter;
	int                 errs_random;
	int                 tests_failed;
	int                 words [8];
	int                 pattern [4] = '{0, 16000, 0, -16000};

	sine_synth_top dut0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.phase_step (phase_step),
		.din        (din),
		.bck        (bck),
		.lrck       (lrck)
	);

	always #10 clk = ~clk;      // 20 ns period

	// --------------------
	// waits and capture
	// --------------------
	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		$display("=== FAIL ===");
		$finish;
	endtask

	task automatic wait_bck_rise();
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen) begin
			@(negedge clk);     // outputs settled here
			seen     = bck && !bck_prev;
			bck_prev = bck;
			cycles++;
			if (!seen && cycles > wait_limit)
				give_up("a rising bck edge");
		end
	endtask

	task automatic wait_frame_edge();
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen) begin
			@(negedge clk);
			seen      = !lrck && lrck_prev;     // frame starts as lrck falls
			lrck_prev = lrck;
			bck_prev  = bck;
			cycles++;
			if (!seen && cycles > 4 * wait_limit)
				give_up("the start of a frame");
		end
	endtask

	task automatic check_near(input string name, input int exp, input int act,
		input int tol, inout int errs);
		if (act > exp + tol || act < exp - tol) begin
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
			errs++;
		end
	endtask

	// shift left with the msb wrapping to bit 0, taps toggle above it
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] nxt;
		nxt = {s[30:0], s[31]};
		if (s[31])
			nxt = nxt ^ {sine_synth_pkg::lfsr_taps, 1'b0};
		return nxt;
	endfunction

	// one frame: msb first, left half then right half
	task automatic next_frame();
		logic [31:0] word;
		word = '0;
		for (int b = 0; b < sine_synth_pkg::bits_per_frame; b++) begin
			wait_bck_rise();
			word = {word[30:0], din};
		end
		if (word[31:16] !== noise_model[31:16]) begin
			$display("** Error noise: expected %h, actual %h", noise_model[31:16], word[31:16]);
			errs_noise++;
		end
		// model steps once per frame
		noise_model = lfsr_step(noise_model);
		right_w = word[15:0];
	endtask

	task automatic report_test(input string name, input int errs);
		$display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
		if (errs != 0)
			tests_failed++;
	endtask

	// --------------------
	// stimulus
	// --------------------
	initial begin
		int first;
		int p;
		clk          = 1'b0;
		arst_n       = 1'b0;
		phase_step   = '0;
		seed         = 32'h7c7b82e1;
		bck_prev     = 1'b0;
		lrck_prev    = 1'b0;
		noise_model  = sine_synth_pkg::lfsr_seed;
		errs_noise   = 0;
		errs_const   = 0;
		errs_quarter = 0;
		errs_random  = 0;
		tests_failed = 0;
		first        = 0;
		p            = -1;
		repeat (10) @(negedge clk);
		arst_n = 1'b1;

		wait_frame_edge();

		// step 0, sine should sit at zero
		for (int i = 1; i <= 8; i++) begin
			next_frame();
			if (i == 3)
				first = right_w;
			if (i >= 3) begin
				check_near("const_sine_same", first, right_w, 0, errs_const);
				check_near("const_sine_zero", 0, right_w, 256, errs_const);
			end
		end
		report_test("const_sine", errs_const);

		// quarter turns, two frames to flush the old phase
		phase_step = 32'h4000_0000;
		next_frame();
		next_frame();
		for (int i = 0; i < 8; i++) begin
			next_frame();
			words[i] = right_w;
		end
		for (int i = 3; i >= 0; i--)
			if (words[i] > 8000)
				p = i;          // first positive peak
		if (p < 0) begin
			$display("quarter_turn: no positive peak found in the first four words");
			errs_quarter++;
		end else begin
			for (int i = 0; i < 8; i++)
				check_near("quarter_turn", pattern[(i - p + 5) % 4], words[i], 256,
					errs_quarter);
			for (int i = 0; i < 4; i++)
				check_near("quarter_period", words[i], words[i+4], 0, errs_quarter);
		end
		report_test("quarter_turn", errs_quarter);

		// random tone, amplitude bound only
		for (int k = 0; k < 2; k++) begin
			phase_step = $random(seed);
			for (int i = 0; i < 6; i++) begin
				next_frame();
				check_near("random_range", 0, right_w, 16400, errs_random);
			end
		end
		report_test("random_step", errs_random);
		report_test("noise", errs_noise);
		// port timing from the bound checker, over the whole run
		report_test("reset_framing", dut0.u_assert.fails);

		$display("tests run 5, failed %0d", tests_failed);
		if (tests_failed == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* filelist.f */
sine_synth_pkg.sv
i2s_timing.sv
sample_sequencer.sv
cordic_sine.sv
lfsr_noise.sv
i2s_serializer.sv
sine_synth_top.sv
sine_synth_assert.sv
tb_sine_synth.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, verdict from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f filelist.f \
	--top-module tb_sine_synth \
	-o sim_tb

# the log decides, so a stopped run still counts as a failure
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "=== PASS ===" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
